// ==== build.f ====
hw/wack_cfg_pkg.sv
hw/wack_types_pkg.sv
hw/wack_fifo.sv
hw/ker_word_tally.sv
hw/burst_word_splitter.sv
hw/release_credit_chain.sv
hw/write_release_top.sv
testbench/tb_release_checker.sv
testbench/tb_write_release.sv

// ==== hw/burst_word_splitter.sv ====
// burst to memory word splitter
// one write acknowledge releases a whole burst

`default_nettype none

module burst_word_splitter (
    input  wire                        clock,
    input  wire                        aclrn,
    input  wire                        i_writeack,     // one acknowledge per burst
    input  wire wack_types_pkg::burst_len_t i_burst_len, // burst fifo head, length minus one
    output logic                       o_burst_rd,     // pop the burst fifo
    output logic                       o_cnt_rd        // pop one memory word from the count fifo
);

    localparam int DEBT_MSB = wack_cfg_pkg::WORD_DEBT_BITS - 1;

    wack_types_pkg::word_debt_t words_add;  // length plus one of the burst acknowledged last cycle
    wack_types_pkg::word_debt_t debt;       // zero or minus the memory words still to pop

    // the burst head is consumed in the same cycle as its acknowledge
    assign o_burst_rd = i_writeack;

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            words_add <= '0;
            debt      <= '0;
        end else begin
            words_add <= i_writeack ? wack_types_pkg::word_debt_t'(i_burst_len) +
                                      wack_types_pkg::word_debt_t'(1) : '0;
            // each pop pays back one memory word of the debt
            debt      <= debt - words_add + wack_types_pkg::word_debt_t'(o_cnt_rd);
        end
    end

    // a negative debt means acknowledged memory words still sit in the count fifo
    assign o_cnt_rd = debt[DEBT_MSB];

    // more outstanding words than the counter can hold would wrap it past zero
    a_debt_not_positive : assert property (@(posedge clock) disable iff (!aclrn)
        debt[DEBT_MSB] || (debt == '0))
        else $error("burst word debt went positive");

endmodule

`default_nettype wire

// ==== hw/ker_word_tally.sv ====
// kernel word tally
// counts finished kernel words per memory word

`default_nettype none

module ker_word_tally (
    input  wire                        clock,
    input  wire                        aclrn,
    input  wire                        i_cmd_can_read,       // controller moves forward this cycle
    input  wire                        i_cmd_rd_ack,         // last section of a kernel word is done
    input  wire                        i_cmd_is_coalescing,  // next section shares this memory word
    output logic                       o_cnt_wr,             // count fifo write strobe
    output wack_types_pkg::ker_count_t o_cnt_data            // kernel words in the finished word
);

    logic mem_word_done;    // registered memory word finished strobe
    logic ker_word_done;    // registered kernel word finished strobe

    // a memory word is finished when the controller advances and does not coalesce further
    // the write to the count fifo lands two cycles after that

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            mem_word_done <= 1'b0;
            ker_word_done <= 1'b0;
            o_cnt_wr      <= 1'b0;
            o_cnt_data    <= '0;
        end else begin
            mem_word_done <= i_cmd_can_read & ~i_cmd_is_coalescing;
            ker_word_done <= i_cmd_rd_ack;
            o_cnt_wr      <= mem_word_done;

            // the accumulator is the write data itself
            // on a write the next memory word starts with whatever kernel strobe is in flight
            if (o_cnt_wr) begin
                o_cnt_data <= wack_types_pkg::ker_count_t'(ker_word_done);
            end else begin
                o_cnt_data <= o_cnt_data + wack_types_pkg::ker_count_t'(ker_word_done);
            end
        end
    end

    // upstream keeps the number of kernel words per memory word below the entry range
    // so a running tally never wraps before its memory word finishes
    a_tally_no_wrap : assert property (@(posedge clock) disable iff (!aclrn)
        (ker_word_done && !o_cnt_wr) |->
            (o_cnt_data != {wack_cfg_pkg::KER_COUNT_WIDTH{1'b1}}))
        else $error("kernel word tally wrapped");

endmodule

`default_nettype wire

// ==== hw/release_credit_chain.sv ====
// release credit chain
// credit counter, mini counter and output occupancy

`default_nettype none

module release_credit_chain (
    input  wire                        clock,
    input  wire                        aclrn,
    input  wire                        i_cnt_rd,       // a memory word was popped from the count fifo
    input  wire wack_types_pkg::ker_count_t i_cnt_data, // kernel words in that memory word
    input  wire                        i_pred_empty,   // predicate fifo has nothing to offer
    input  wire                        i_pred_data,    // head entry is predicated
    output logic                       o_pred_rd_ack,  // pop the predicate fifo
    output logic                       o_valid,        // a transfer is available downstream
    input  wire                        i_stall         // downstream back-pressure
);

    localparam int MINI_MSB = wack_cfg_pkg::MINI_COUNT_BITS - 1;

    wack_types_pkg::ker_count_t  credit_incr;       // registered copy of the popped entry
    wack_types_pkg::occ_count_t  credit;            // acknowledged kernel words not yet moved on
    logic                        credit_two_plus;   // credit was two or more last cycle
    logic                        credit_decr;       // move one unit into the mini counter
    logic                        mini_incr;         // credit_decr one cycle later
    logic                        mini_decr;         // a normal entry consumes one unit
    wack_types_pkg::mini_count_t mini;              // -1 means empty
    logic                        mini_nonzero;
    logic                        mini_af;
    logic                        out_incr;          // o_pred_rd_ack one cycle later
    logic                        out_decr;          // downstream accepted a transfer
    wack_types_pkg::out_count_t  out_count;
    wack_types_pkg::out_count_t  out_next;
    logic                        out_af;

    //////////////////////////////
    // wide credit counter
    //////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            credit_incr     <= '0;
            credit          <= '0;
            credit_two_plus <= 1'b0;
        end else begin
            credit_incr     <= i_cnt_rd ? i_cnt_data : '0;
            credit          <= credit + wack_types_pkg::occ_count_t'(credit_incr)
                                      - wack_types_pkg::occ_count_t'(credit_decr);
            credit_two_plus <= (credit >= wack_types_pkg::occ_count_t'(2));
        end
    end

    // at most one unit leaves per cycle so two or more last cycle still means nonzero now
    // the lsb covers the remaining case of exactly one and avoids a wide zero compare
    assign credit_decr = (credit_two_plus | credit[0]) & ~mini_af;

    //////////////////////////////
    // mini counter
    //////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            mini_incr <= 1'b0;
            mini      <= '1;                     // starts at -1 which reads as empty
            mini_af   <= 1'b0;
        end else begin
            mini_incr <= credit_decr;
            mini      <= mini + wack_types_pkg::mini_count_t'(mini_incr)
                              - wack_types_pkg::mini_count_t'(mini_decr);
            mini_af   <= ~mini[MINI_MSB] & mini[MINI_MSB-1];   // +4 or more
        end
    end

    assign mini_nonzero = ~mini[MINI_MSB];     // a sign bit of zero means at least one unit

    // a normal entry at the head of the predicate fifo needs one unit of credit
    assign mini_decr = ~out_af & ~i_pred_empty & ~i_pred_data & mini_nonzero;

    // a predicated entry has no memory write behind it and goes straight through
    assign o_pred_rd_ack = ~out_af & ~i_pred_empty & (i_pred_data | mini_nonzero);

    //////////////////////////////
    // output occupancy
    //////////////////////////////

    assign out_decr = o_valid & ~i_stall;
    assign out_next = out_count + wack_types_pkg::out_count_t'(out_incr)
                                - wack_types_pkg::out_count_t'(out_decr);

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            out_incr  <= 1'b0;
            out_count <= '0;
            o_valid   <= 1'b0;
            out_af    <= 1'b1;                   // nothing is acknowledged while in reset
        end else begin
            out_incr  <= o_pred_rd_ack;
            out_count <= out_next;
            o_valid   <= (out_next != '0);
            // one acknowledge can still be in flight when the flag rises
            out_af    <= (out_next >= wack_types_pkg::out_count_t'(
                                          wack_cfg_pkg::OUTPUT_CAPACITY - 1));
        end
    end

    // the registered almost full and the pending increment together stay within capacity
    a_out_no_overflow : assert property (@(posedge clock) disable iff (!aclrn)
        out_count <= wack_types_pkg::out_count_t'(wack_cfg_pkg::OUTPUT_CAPACITY))
        else $error("output occupancy counter overflowed");

endmodule

`default_nettype wire

// ==== hw/wack_cfg_pkg.sv ====
// write acknowledge release path
// sizes and cutoffs

`default_nettype none

package wack_cfg_pkg;

    // one count fifo entry holds the kernel words that finished inside one memory word
    localparam int KER_COUNT_WIDTH    = 4;
    localparam int BURSTCOUNT_WIDTH   = 4;      // snoop burst length is stored as length minus one

    // both fifos share one depth so the burst fifo can never run ahead of the count fifo
    localparam int ACK_FIFO_DEPTH     = 32;
    localparam int ACK_FIFO_ADDR_BITS = $clog2(ACK_FIFO_DEPTH);
    localparam int ACK_FIFO_OCC_BITS  = ACK_FIFO_ADDR_BITS + 1;

    // almost full rises with three free slots or fewer
    // one clock to stop the command fifo, one to the finished strobe and one to the fifo write
    localparam int ACK_FIFO_AF_CUTOFF = 3;

    localparam int TOTAL_OCC_BITS     = 10;     // nearly every write in flight can pile up here
    localparam int WORD_DEBT_BITS     = ACK_FIFO_ADDR_BITS + 1;  // msb is the sign of the debt
    localparam int MINI_COUNT_BITS    = 4;      // holds -1 to +6 in practice

    // the output counter only needs to cover the round trip of the almost full flag
    localparam int OUTPUT_CAPACITY    = 8;
    localparam int OUT_COUNT_BITS     = $clog2(OUTPUT_CAPACITY) + 1;

endpackage

`default_nettype wire

// ==== hw/wack_fifo.sv ====
// show-ahead fifo
// register array with occupancy and almost full

`default_nettype none

module wack_fifo #(
    parameter type payload_t = logic    // kernel word counts or burst lengths
) (
    input  wire           clock,
    input  wire           aclrn,
    input  wire           i_wr,             // write strobe
    input  wire payload_t i_wr_data,
    input  wire           i_rd,             // pop the head entry
    output payload_t      o_rd_data,        // head entry, valid whenever o_empty is low
    output logic          o_empty,
    output logic          o_almost_full     // registered against the cutoff
);

    typedef logic [wack_cfg_pkg::ACK_FIFO_ADDR_BITS-1:0] addr_t;
    typedef logic [wack_cfg_pkg::ACK_FIFO_OCC_BITS-1:0]  occ_t;

    payload_t mem [wack_cfg_pkg::ACK_FIFO_DEPTH];  // storage has no reset
    addr_t    wr_ptr;
    addr_t    rd_ptr;
    occ_t     occ;                                  // entries currently held
    occ_t     occ_next;

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // the head is read straight out of the array so the consumer sees it a cycle early
    assign o_rd_data = mem[rd_ptr];

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    assign occ_next = occ + occ_t'(i_wr) - occ_t'(i_rd);
    assign o_empty  = (occ == '0);

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            occ           <= '0;
            o_almost_full <= 1'b0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + addr_t'(1);  // depth is a power of two so it wraps by itself
            end
            if (i_rd) begin
                rd_ptr <= rd_ptr + addr_t'(1);
            end
            occ <= occ_next;
            // flag rises as the occupancy reaches depth minus cutoff
            o_almost_full <= (occ_next >= occ_t'(wack_cfg_pkg::ACK_FIFO_DEPTH -
                                                 wack_cfg_pkg::ACK_FIFO_AF_CUTOFF));
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // the writer must have reacted to almost full before the last slot is used
    a_no_write_when_full : assert property (@(posedge clock) disable iff (!aclrn)
        i_wr |-> (occ != occ_t'(wack_cfg_pkg::ACK_FIFO_DEPTH)))
        else $error("wack_fifo written while full");

    // the reader only pops entries that were written earlier
    a_no_read_when_empty : assert property (@(posedge clock) disable iff (!aclrn)
        i_rd |-> !o_empty)
        else $error("wack_fifo read while empty");

endmodule

`default_nettype wire

// ==== hw/wack_types_pkg.sv ====
// write acknowledge release path
// counter and payload types

`default_nettype none

package wack_types_pkg;

    // kernel words finished inside one memory word
    typedef logic [wack_cfg_pkg::KER_COUNT_WIDTH-1:0] ker_count_t;

    // burst length minus one as reported by the burst coalescer
    typedef logic [wack_cfg_pkg::BURSTCOUNT_WIDTH-1:0] burst_len_t;

    // wide credit count of kernel words that memory has acknowledged
    typedef logic [wack_cfg_pkg::TOTAL_OCC_BITS-1:0] occ_count_t;

    // memory words popped from a burst but not yet popped from the count fifo
    // the value is zero or negative so the msb reads as "words outstanding"
    typedef logic [wack_cfg_pkg::WORD_DEBT_BITS-1:0] word_debt_t;

    // small offset counter where -1 means empty
    typedef logic signed [wack_cfg_pkg::MINI_COUNT_BITS-1:0] mini_count_t;

    // valids waiting for the kernel downstream
    typedef logic [wack_cfg_pkg::OUT_COUNT_BITS-1:0] out_count_t;

endpackage

`default_nettype wire

// ==== hw/write_release_top.sv ====
// write acknowledge release path
// top level

`default_nettype none

module write_release_top (
    input  wire                        clock,
    input  wire                        aclrn,

    // unaligned controller
    input  wire                        i_cmd_can_read,
    input  wire                        i_cmd_rd_ack,
    input  wire                        i_cmd_is_coalescing,
    output logic                       o_writeack_fifo_almost_full,  // stop issuing memory words

    // burst coalescer snoop
    input  wire                        i_burst_snoop_valid,
    input  wire wack_types_pkg::burst_len_t i_burst_snoop_len,

    // memory write acknowledge, one per burst
    input  wire                        i_writeack,

    // read side of the predicate fifo
    input  wire                        i_pred_empty,
    input  wire                        i_pred_data,
    output logic                       o_pred_rd_ack,

    // kernel downstream
    output logic                       o_valid,
    input  wire                        i_stall
);

    logic                       cnt_wr;
    wack_types_pkg::ker_count_t cnt_data;
    logic                       cnt_rd;
    wack_types_pkg::ker_count_t cnt_head;
    logic                       burst_rd;
    wack_types_pkg::burst_len_t burst_head;
    logic                       burst_empty;

    ker_word_tally tally_i (
        .clock               (clock),
        .aclrn               (aclrn),
        .i_cmd_can_read      (i_cmd_can_read),
        .i_cmd_rd_ack        (i_cmd_rd_ack),
        .i_cmd_is_coalescing (i_cmd_is_coalescing),
        .o_cnt_wr            (cnt_wr),
        .o_cnt_data          (cnt_data)
    );

    // kernel words per memory word, waiting for their burst to be acknowledged
    wack_fifo #(
        .payload_t (wack_types_pkg::ker_count_t)
    ) count_fifo_i (
        .clock         (clock),
        .aclrn         (aclrn),
        .i_wr          (cnt_wr),
        .i_wr_data     (cnt_data),
        .i_rd          (cnt_rd),
        .o_rd_data     (cnt_head),
        .o_empty       (),
        .o_almost_full (o_writeack_fifo_almost_full)
    );

    // burst lengths in issue order
    wack_fifo #(
        .payload_t (wack_types_pkg::burst_len_t)
    ) burst_fifo_i (
        .clock         (clock),
        .aclrn         (aclrn),
        .i_wr          (i_burst_snoop_valid),
        .i_wr_data     (i_burst_snoop_len),
        .i_rd          (burst_rd),
        .o_rd_data     (burst_head),
        .o_empty       (burst_empty),
        .o_almost_full ()
    );

    burst_word_splitter splitter_i (
        .clock       (clock),
        .aclrn       (aclrn),
        .i_writeack  (i_writeack),
        .i_burst_len (burst_head),
        .o_burst_rd  (burst_rd),
        .o_cnt_rd    (cnt_rd)
    );

    release_credit_chain chain_i (
        .clock         (clock),
        .aclrn         (aclrn),
        .i_cnt_rd      (cnt_rd),
        .i_cnt_data    (cnt_head),
        .i_pred_empty  (i_pred_empty),
        .i_pred_data   (i_pred_data),
        .o_pred_rd_ack (o_pred_rd_ack),
        .o_valid       (o_valid),
        .i_stall       (i_stall)
    );

    // memory only acknowledges bursts the coalescer has already issued
    a_ack_has_burst : assert property (@(posedge clock) disable iff (!aclrn)
        i_writeack |-> !burst_empty)
        else $error("write acknowledge without a recorded burst");

endmodule

`default_nettype wire

// ==== testbench/tb_release_checker.sv ====
// release checker
// watches the dut ports and bounds each transfer by credit

`default_nettype none

module tb_release_checker (
    input  wire clock,
    input  wire aclrn,
    input  wire i_writeack,
    input  wire i_pred_empty,
    input  wire i_pred_data,
    input  wire i_pred_rd_ack,
    input  wire i_valid,
    input  wire i_stall
);

    int credit;         // non-predicated kernel words behind acknowledged bursts
    int valids;         // accepted transfers in the current test
    int normal_acc;     // accepted transfers that came from normal entries
    int words_per_ack;  // kernel words that one write acknowledge stands for
    int errors;         // all failed checks over the run
    int test_errors;
    int test_idx;
    int acks;           // predicate entries the dut has popped in the current test
    bit expect_seq[$];  // predicate flags in the order the entries were queued

    initial begin
        credit        = 0;
        valids        = 0;
        normal_acc    = 0;
        words_per_ack = 0;
        errors        = 0;
        test_errors   = 0;
        test_idx      = 0;
        acks          = 0;
    end

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    // the testbench calls this before it starts driving a new row
    task automatic start_test(input int idx, input int words, input bit seq[$]);
        test_idx      = idx;
        words_per_ack = words;
        expect_seq    = seq;
        credit        = 0;
        valids        = 0;
        normal_acc    = 0;
        test_errors   = 0;
        acks          = 0;
    endtask

    task automatic finish_test(input int expected);
        if (valids != expected) begin
            report_error($sformatf("test %0d released %0d valids, expected %0d",
                                   test_idx, valids, expected));
        end
        $display("test %0d done: %0d valids, %0d credit, %0d errors",
                 test_idx, valids, credit, test_errors);
    endtask

    // outputs settle after the rising edge so everything is sampled on the falling edge
    always @(negedge clock) begin
        if (aclrn) begin
            if (i_writeack) begin
                credit = credit + words_per_ack;        // a whole burst is now in memory
            end
            if (i_pred_rd_ack) begin
                if (i_pred_empty) begin
                    report_error("predicate fifo acknowledged while empty");
                end else begin
                    acks = acks + 1;
                end
            end
            if (i_valid && !i_stall) begin
                if (valids >= acks) begin
                    report_error("transfer without a predicate entry behind it");
                end else if (valids >= expect_seq.size()) begin
                    report_error("more transfers than queued predicate entries");
                end else if (!expect_seq[valids]) begin
                    // the pattern position of this transfer says it needed credit
                    normal_acc = normal_acc + 1;
                    if (normal_acc > credit) begin
                        report_error($sformatf("normal transfer %0d exceeds credit %0d",
                                               normal_acc, credit));
                    end
                end
                valids = valids + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_write_release.sv ====
// write release testbench
// scenario table, memory and predicate fifo models

`default_nettype none

module tb_write_release;

    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT   = 3000;   // cycles allowed for any single wait

    // bursts, memory words per burst, kernel words per memory word,
    // predicate pattern, withhold acknowledges, random stall
    int       t_bursts [NUM_TESTS] = '{1, 2, 1, 3, 2};
    int       t_words  [NUM_TESTS] = '{4, 3, 2, 4, 15};
    int       t_kers   [NUM_TESTS] = '{2, 3, 2, 1, 1};
    bit [7:0] t_pred   [NUM_TESTS] = '{8'h00, 8'h00, 8'h07, 8'h25, 8'h00};
    bit       t_hold   [NUM_TESTS] = '{0, 0, 1, 0, 1};
    bit       t_rstall [NUM_TESTS] = '{0, 0, 0, 1, 0};

    logic clock;
    logic aclrn;
    logic cmd_can_read;
    logic cmd_rd_ack;
    logic cmd_is_coalescing;
    logic burst_snoop_valid;
    wack_types_pkg::burst_len_t burst_snoop_len;
    logic writeack;
    logic pred_empty;
    logic pred_data;
    logic stall;
    logic almost_full;
    logic pred_rd_ack;
    logic valid;

    int   seed;
    int   errors;
    int   cycle;
    bit   rand_stall;
    logic ack_seen;        // o_pred_rd_ack sampled on the falling edge
    bit   pred_q[$];       // predicate fifo model contents
    int   ack_due[$];      // memory model, cycles at which acknowledges go out

    write_release_top dut_i (
        .clock (clock), .aclrn (aclrn),
        .i_cmd_can_read (cmd_can_read), .i_cmd_rd_ack (cmd_rd_ack),
        .i_cmd_is_coalescing (cmd_is_coalescing),
        .o_writeack_fifo_almost_full (almost_full),
        .i_burst_snoop_valid (burst_snoop_valid), .i_burst_snoop_len (burst_snoop_len),
        .i_writeack (writeack),
        .i_pred_empty (pred_empty), .i_pred_data (pred_data), .o_pred_rd_ack (pred_rd_ack),
        .o_valid (valid), .i_stall (stall)
    );

    tb_release_checker checker_i (
        .clock (clock), .aclrn (aclrn), .i_writeack (writeack),
        .i_pred_empty (pred_empty), .i_pred_data (pred_data), .i_pred_rd_ack (pred_rd_ack),
        .i_valid (valid), .i_stall (stall)
    );

    always #50 clock = ~clock;

    always @(negedge clock) ack_seen = pred_rd_ack;

    // predicate fifo, memory and stall models all move on the rising edge
    always @(posedge clock) begin
        cycle = cycle + 1;
        if (aclrn && ack_seen === 1'b1 && pred_q.size() > 0) begin
            void'(pred_q.pop_front());
        end
        pred_empty <= (pred_q.size() == 0);
        pred_data  <= (pred_q.size() > 0) ? pred_q[0] : 1'b0;
        if (ack_due.size() > 0 && cycle >= ack_due[0]) begin
            writeack <= 1'b1;
            void'(ack_due.pop_front());
        end else begin
            writeack <= 1'b0;
        end
        stall <= rand_stall ? $random(seed) % 2 != 0 : 1'b0;
    end

    task automatic end_run();
        int total;
        total = errors + checker_i.errors;
        $display("tests %0d, tb errors %0d, checker errors %0d", NUM_TESTS, errors,
                 checker_i.errors);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
            errors = errors + 1;
        end
    endtask

    // one memory word is K kernel words, coalescing until the last one
    task automatic write_burst(input int m, input int k, input bit hold);
        for (int w = 0; w < m; w++) begin
            for (int j = 0; j < k; j++) begin
                @(posedge clock);
                cmd_can_read      <= 1'b1;
                cmd_rd_ack        <= 1'b1;
                cmd_is_coalescing <= (j != k - 1);
                burst_snoop_valid <= (w == m - 1) && (j == k - 1);
                burst_snoop_len   <= wack_types_pkg::burst_len_t'(m - 1);
            end
        end
        @(posedge clock);
        cmd_can_read      <= 1'b0;
        cmd_rd_ack        <= 1'b0;
        cmd_is_coalescing <= 1'b0;
        burst_snoop_valid <= 1'b0;
        if (!hold) begin
            ack_due.push_back(cycle + 4);     // memory answers a few cycles after the last word
        end
    endtask

    // walks the scenario table and gives up at the first wait that times out
    task automatic run_tests();
        bit seq[$];
        int normals;
        int lead;
        int n;
        int waited;

        for (int t = 0; t < NUM_TESTS; t++) begin
            // the pattern repeats every 8 entries until all normal entries are queued
            seq.delete();
            normals = t_bursts[t] * t_words[t] * t_kers[t];
            n = 0;
            for (int i = 0; n < normals; i++) begin
                seq.push_back(t_pred[t][i % 8]);
                if (!t_pred[t][i % 8]) n++;
            end
            lead = 0;
            while (lead < seq.size() && seq[lead]) lead++;
            checker_i.start_test(t, t_words[t] * t_kers[t], seq);
            @(posedge clock);
            rand_stall = t_rstall[t];
            foreach (seq[i]) pred_q.push_back(seq[i]);
            for (int b = 0; b < t_bursts[t]; b++) write_burst(t_words[t], t_kers[t], t_hold[t]);

            if (t_hold[t]) begin
                repeat (200) @(posedge clock);    // window with nothing acknowledged
                @(negedge clock);
                if (checker_i.valids != lead) begin
                    $display("CHECK FAILED at %0t: %0d valids without acknowledge, expected %0d",
                             $time, checker_i.valids, lead);
                    errors = errors + 1;
                end
                check_flag(almost_full, normals >= wack_cfg_pkg::ACK_FIFO_DEPTH -
                           wack_cfg_pkg::ACK_FIFO_AF_CUTOFF, "almost full while withheld");
                for (int b = 0; b < t_bursts[t]; b++) ack_due.push_back(cycle + 2 + 2 * b);
            end

            waited = 0;
            while (checker_i.valids < seq.size() || almost_full !== 1'b0) begin
                @(negedge clock);
                waited++;
                if (waited > TIMEOUT) begin
                    $display("test %0d timed out waiting for all valids to drain at time %0t",
                             t, $time);
                    errors = errors + 1;
                    return;
                end
            end
            rand_stall = 0;
            repeat (5) @(negedge clock);
            checker_i.finish_test(seq.size());
        end
    endtask

    initial begin
        clock             = 1'b0;
        cycle             = 0;
        errors            = 0;
        seed              = 67;
        rand_stall        = 0;
        aclrn             <= 1'b0;
        cmd_can_read      <= 1'b0;
        cmd_rd_ack        <= 1'b0;
        cmd_is_coalescing <= 1'b0;
        burst_snoop_valid <= 1'b0;
        burst_snoop_len   <= '0;
        writeack          <= 1'b0;
        pred_empty        <= 1'b1;
        pred_data         <= 1'b0;
        stall             <= 1'b0;
        repeat (10) @(posedge clock);
        aclrn <= 1'b1;
        @(negedge clock);
        check_flag(valid, 1'b0, "o_valid after reset");
        check_flag(pred_rd_ack, 1'b0, "o_pred_rd_ack after reset");
        check_flag(almost_full, 1'b0, "almost full after reset");

        run_tests();
        end_run();
    end

endmodule

`default_nettype wire
